/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = um_tb
FILELIST  = um_top.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* design/um_fwd.sv */
`timescale 1ns/1ps

module um_fwd (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   desc_avail,
	input  um_meta_pkg::pkt_desc_t desc_head,
	output logic                   rd,
	input  um_pkt_pkg::pkt_word_t  rdata,
	output um_pkt_pkg::pkt_word_t  pktout,
	output logic                   pktout_data_wr,
	output logic                   pktout_valid,
	output logic                   pktout_valid_wr,
	output um_pkt_pkg::pkt_cnt_t   esw_pktout_cnt
);
	import um_pkt_pkg::*;
	import um_meta_pkg::*;

	typedef enum logic {
		IDLE,
		READ
	} state_t;

	state_t    state;
	pkt_len_t  left_q; // words still to read
	dest_t     dest_q;
	port_id_t  out_port;
	logic      rd_q;   // rdata valid
	logic      tail_in;
	pkt_word_t word;

	assign rd = state == READ;
	assign pktout_valid = 1'b1;
	assign out_port = (dest_q == DEST_CPU) ? CPU_PORT : PEER_PORT;
	assign tail_in = rd_q && rdata.tag == TAG_TAIL;

	always_comb begin
		word = rdata;
		if (rdata.tag == TAG_HEAD)
			word.data[META_OUTPORT_LSB +: PORT_W] = out_port;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			rd_q <= 1'b0;
			pktout_data_wr <= 1'b0;
			pktout_valid_wr <= 1'b0;
			esw_pktout_cnt <= '0;
		end else begin
			rd_q <= rd;
			pktout_data_wr <= rd_q;
			pktout_valid_wr <= tail_in;
			if (tail_in)
				esw_pktout_cnt <= esw_pktout_cnt + 1'b1;
			case (state)
				IDLE: begin
					if (desc_avail)
						state <= READ;
				end
				default: begin
					if (left_q == pkt_len_t'(1))
						state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && desc_avail) begin
			left_q <= desc_head.len;
			dest_q <= desc_head.dest;
		end else if (rd) begin
			left_q <= left_q - 1'b1;
		end
		pktout <= word;
	end

endmodule

/* design/um_meta_pkg.sv */
package um_meta_pkg;

	localparam int PORT_W = 6;

	// field positions inside metadata word 0
	localparam int META_INPORT_LSB = 120;
	localparam int META_OUTPORT_LSB = 108;

	typedef logic [PORT_W-1:0] port_id_t;

	localparam port_id_t CPU_PORT = 6'd63;
	localparam port_id_t PEER_PORT = 6'd1;

	typedef enum logic {
		DEST_CPU,
		DEST_PEER
	} dest_t;

	localparam int BUF_WORDS = 64;
	localparam int BUF_AW = $clog2(BUF_WORDS);
	localparam int DESC_DEPTH = 8;
	localparam int DESC_AW = $clog2(DESC_DEPTH);
	localparam int LEN_W = 7;

	typedef logic [BUF_AW-1:0] buf_addr_t;
	typedef logic [LEN_W-1:0] pkt_len_t;

	typedef struct packed {
		dest_t    dest;
		port_id_t inport;
		pkt_len_t len; // words incl. metadata
	} pkt_desc_t;

endpackage

/* design/um_parser.sv */
`timescale 1ns/1ps

module um_parser (
	input  logic                   clk,
	input  logic                   rst_n,
	input  um_pkt_pkg::pkt_word_t  pktin,
	input  logic                   pktin_data_wr,
	input  logic                   pktin_valid,
	input  logic                   pktin_valid_wr,
	input  um_pkt_pkg::mac_addr_t  local_mac_addr,
	input  um_pkt_pkg::mac_addr_t  direct_mac_addr,
	output logic                   buf_wr,
	output um_pkt_pkg::pkt_word_t  buf_wdata,
	output logic                   buf_commit,
	output logic                   buf_abort,
	output um_meta_pkg::pkt_desc_t buf_desc,
	output um_pkt_pkg::pkt_cnt_t   esw_pktin_cnt
);
	import um_pkt_pkg::*;
	import um_meta_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		META1,
		HDR,
		BODY,
		SKIP
	} state_t;

	state_t    state;
	port_id_t  inport_q;
	dest_t     dest_q;
	dest_t     hdr_dest;
	pkt_len_t  len_q;
	mac_addr_t dmac;
	logic      cls_q; // header matched one of the macs
	logic      fin_q; // packet ended last cycle
	logic      ok_q;
	logic      hit;
	logic      is_head;
	logic      is_tail;
	logic      good_end;
	logic      tail_ok;
	logic      accept;

	assign dmac = pktin.data[MAC_DST_LSB +: MAC_W];
	assign hit = (dmac == local_mac_addr) || (dmac == direct_mac_addr);
	assign hdr_dest = (dmac == local_mac_addr) ? DEST_CPU : DEST_PEER;
	assign is_head = pktin_data_wr && pktin.tag == TAG_HEAD;
	assign is_tail = pktin_data_wr && pktin.tag == TAG_TAIL;
	assign good_end = pktin_valid_wr && pktin_valid;

	always_comb begin
		case (state)
			IDLE:             accept = is_head;
			META1, HDR, BODY: accept = pktin_data_wr && !is_head;
			default:          accept = 1'b0;
		endcase
	end

	// a tail in HDR is classified on the spot
	always_comb begin
		case (state)
			HDR:     tail_ok = hit;
			BODY:    tail_ok = cls_q;
			default: tail_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			cls_q <= 1'b0;
			fin_q <= 1'b0;
			ok_q <= 1'b0;
			buf_wr <= 1'b0;
			buf_commit <= 1'b0;
			buf_abort <= 1'b0;
			esw_pktin_cnt <= '0;
		end else begin
			fin_q <= 1'b0;
			buf_wr <= accept;
			buf_commit <= fin_q && ok_q;
			buf_abort <= fin_q && !ok_q;
			if (is_head)
				esw_pktin_cnt <= esw_pktin_cnt + 1'b1;
			if (pktin_data_wr) begin
				case (state)
					IDLE: begin
						if (is_head)
							state <= META1;
						else if (!is_tail)
							state <= SKIP; // stray word
					end
					META1, HDR, BODY: begin
						if (is_head) begin // head inside a packet
							state <= SKIP;
							fin_q <= 1'b1;
							ok_q <= 1'b0;
						end else if (is_tail) begin
							state <= IDLE;
							fin_q <= 1'b1;
							ok_q <= good_end && tail_ok;
						end else if (state == META1) begin
							state <= HDR;
						end else if (state == HDR) begin
							state <= BODY;
							cls_q <= hit;
						end
					end
					default: begin
						if (is_tail)
							state <= IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			len_q <= (state == IDLE) ? pkt_len_t'(1) : len_q + 1'b1;
		end
		if (state == IDLE && is_head)
			inport_q <= pktin.data[META_INPORT_LSB +: PORT_W];
		if (state == HDR && accept)
			dest_q <= hdr_dest;
		buf_wdata <= pktin;
		if (fin_q)
			buf_desc <= '{dest: dest_q, inport: inport_q, len: len_q};
	end

endmodule

/* design/um_pkt_buf.sv */
`timescale 1ns/1ps

module um_pkt_buf (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   buf_wr,
	input  um_pkt_pkg::pkt_word_t  buf_wdata,
	input  logic                   buf_commit,
	input  logic                   buf_abort,
	input  um_meta_pkg::pkt_desc_t buf_desc,
	output logic                   desc_avail,
	output um_meta_pkg::pkt_desc_t desc_head,
	input  logic                   rd,
	output um_pkt_pkg::pkt_word_t  rdata,
	output um_pkt_pkg::pkt_cnt_t   bufm_drop_cnt
);
	import um_pkt_pkg::*;
	import um_meta_pkg::*;

	pkt_word_t mem [BUF_WORDS];
	pkt_desc_t ring [DESC_DEPTH];

	buf_addr_t        wr_ptr; // speculative pointer ahead of cmt_ptr
	buf_addr_t        cmt_ptr;
	buf_addr_t        rd_ptr;
	buf_addr_t        base;
	logic [DESC_AW:0] dwr_ptr;
	logic [DESC_AW:0] drd_ptr;
	logic             ovf_q;
	logic             ovf_live;
	logic             ring_full;
	logic             drop;
	logic             push;
	logic             pop;
	logic             rollback;
	logic             fill;
	logic             do_wr;

	assign ring_full = (dwr_ptr[DESC_AW] != drd_ptr[DESC_AW]) &&
		(dwr_ptr[DESC_AW-1:0] == drd_ptr[DESC_AW-1:0]);
	assign drop = buf_commit && (ovf_q || ring_full);
	assign push = buf_commit && !drop;
	assign rollback = buf_abort || drop;

	// a write in the commit cycle already belongs to the next packet
	assign base = rollback ? cmt_ptr : wr_ptr;
	assign ovf_live = (buf_commit || buf_abort) ? 1'b0 : ovf_q;
	assign fill = buf_wr && !ovf_live && ((base + 1'b1) == rd_ptr);
	assign do_wr = buf_wr && !ovf_live && !fill;

	assign pop = rd && mem[rd_ptr].tag == TAG_TAIL;
	assign desc_avail = dwr_ptr != drd_ptr;
	assign desc_head = ring[drd_ptr[DESC_AW-1:0]];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			cmt_ptr <= '0;
			rd_ptr <= '0;
			dwr_ptr <= '0;
			drd_ptr <= '0;
			ovf_q <= 1'b0;
			bufm_drop_cnt <= '0;
		end else begin
			wr_ptr <= do_wr ? base + 1'b1 : base;
			ovf_q <= ovf_live || fill;
			if (push) begin
				cmt_ptr <= wr_ptr;
				dwr_ptr <= dwr_ptr + 1'b1;
			end
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (pop)
				drd_ptr <= drd_ptr + 1'b1;
			if (drop)
				bufm_drop_cnt <= bufm_drop_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[base] <= buf_wdata;
		if (push)
			ring[dwr_ptr[DESC_AW-1:0]] <= buf_desc;
		if (rd)
			rdata <= mem[rd_ptr];
	end

endmodule

/* design/um_pkt_pkg.sv */
package um_pkt_pkg;

	localparam int DATA_W = 128;
	localparam int EMPTY_W = 4;
	localparam int MAC_W = 48;
	localparam int CNT_W = 32;

	// dmac occupies the top of the first data word with smac below it
	localparam int MAC_DST_LSB = 80;

	typedef enum logic [1:0] {
		TAG_HEAD = 2'b01,
		TAG_MID  = 2'b11,
		TAG_TAIL = 2'b10
	} pkt_tag_t;

	typedef logic [DATA_W-1:0] pkt_data_t;
	typedef logic [EMPTY_W-1:0] pkt_empty_t;
	typedef logic [MAC_W-1:0] mac_addr_t;
	typedef logic [CNT_W-1:0] pkt_cnt_t;

	// one bus word of 134 bits
	typedef struct packed {
		pkt_tag_t   tag;
		pkt_empty_t empty; // empty bytes in the last word
		pkt_data_t  data;
	} pkt_word_t;

endpackage

/* design/um_top.sv */
`timescale 1ns/1ps

module um_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  um_pkt_pkg::pkt_word_t pktin,
	input  logic                  pktin_data_wr,
	input  logic                  pktin_valid,
	input  logic                  pktin_valid_wr,
	input  um_pkt_pkg::mac_addr_t local_mac_addr,
	input  um_pkt_pkg::mac_addr_t direct_mac_addr,
	output um_pkt_pkg::pkt_word_t pktout,
	output logic                  pktout_data_wr,
	output logic                  pktout_valid,
	output logic                  pktout_valid_wr,
	output um_pkt_pkg::pkt_cnt_t  esw_pktin_cnt,
	output um_pkt_pkg::pkt_cnt_t  esw_pktout_cnt,
	output um_pkt_pkg::pkt_cnt_t  bufm_drop_cnt
);
	import um_pkt_pkg::*;
	import um_meta_pkg::*;

	logic      buf_wr;
	pkt_word_t buf_wdata;
	logic      buf_commit;
	logic      buf_abort;
	pkt_desc_t buf_desc;
	logic      desc_avail;
	pkt_desc_t desc_head;
	logic      rd;
	pkt_word_t rdata;

	um_parser u_parser (
		.clk             (clk),
		.rst_n           (rst_n),
		.pktin           (pktin),
		.pktin_data_wr   (pktin_data_wr),
		.pktin_valid     (pktin_valid),
		.pktin_valid_wr  (pktin_valid_wr),
		.local_mac_addr  (local_mac_addr),
		.direct_mac_addr (direct_mac_addr),
		.buf_wr          (buf_wr),
		.buf_wdata       (buf_wdata),
		.buf_commit      (buf_commit),
		.buf_abort       (buf_abort),
		.buf_desc        (buf_desc),
		.esw_pktin_cnt   (esw_pktin_cnt)
	);

	um_pkt_buf u_buf (
		.clk           (clk),
		.rst_n         (rst_n),
		.buf_wr        (buf_wr),
		.buf_wdata     (buf_wdata),
		.buf_commit    (buf_commit),
		.buf_abort     (buf_abort),
		.buf_desc      (buf_desc),
		.desc_avail    (desc_avail),
		.desc_head     (desc_head),
		.rd            (rd),
		.rdata         (rdata),
		.bufm_drop_cnt (bufm_drop_cnt)
	);

	um_fwd u_fwd (
		.clk             (clk),
		.rst_n           (rst_n),
		.desc_avail      (desc_avail),
		.desc_head       (desc_head),
		.rd              (rd),
		.rdata           (rdata),
		.pktout          (pktout),
		.pktout_data_wr  (pktout_data_wr),
		.pktout_valid    (pktout_valid),
		.pktout_valid_wr (pktout_valid_wr),
		.esw_pktout_cnt  (esw_pktout_cnt)
	);

endmodule

/* um_top.f */
design/um_pkt_pkg.sv
design/um_meta_pkg.sv
design/um_parser.sv
design/um_pkt_buf.sv
design/um_fwd.sv
design/um_top.sv
verification/um_tb_chk.sv
verification/um_scoreboard.sv
verification/um_tb.sv

/* verification/um_scoreboard.sv */
`timescale 1ns/1ps

module um_scoreboard (
	input  logic                  clk,
	input  logic                  rst_n,
	input  um_pkt_pkg::pkt_word_t pktin,
	input  logic                  pktin_data_wr,
	input  logic                  pktin_valid,
	input  logic                  pktin_valid_wr,
	input  um_pkt_pkg::mac_addr_t local_mac_addr,
	input  um_pkt_pkg::mac_addr_t direct_mac_addr,
	input  um_pkt_pkg::pkt_word_t pktout,
	input  logic                  pktout_data_wr,
	input  logic                  pktout_valid,
	input  logic                  pktout_valid_wr,
	input  um_pkt_pkg::pkt_cnt_t  esw_pktin_cnt,
	input  um_pkt_pkg::pkt_cnt_t  esw_pktout_cnt,
	input  um_pkt_pkg::pkt_cnt_t  bufm_drop_cnt,
	input  logic                  chk_counts,
	output int                    exp_left,
	output logic                  counts_done,
	output int                    data_errs,
	output int                    proto_errs,
	output int                    cnt_errs
);
	import um_pkt_pkg::*;
	import um_meta_pkg::*;

	pkt_word_t cur [$];   // packet being received
	pkt_word_t exp_q [$];
	int        n_in = 0;
	int        n_kept = 0;
	int        n_drop = 0;
	int        n_data = 0;
	int        n_proto = 0;
	int        n_cnt = 0;
	int        n_left = 0;
	logic      done = 1'b0;
	logic      in_burst = 1'b0;

	assign exp_left = n_left;
	assign counts_done = done;
	assign data_errs = n_data;
	assign proto_errs = n_proto;
	assign cnt_errs = n_cnt;

	task automatic close_pkt(input logic good);
		mac_addr_t dmac;
		logic      to_cpu;
		logic      to_peer;
		pkt_word_t w;
		if (cur.size() < 3)
			return;
		dmac = cur[2].data[MAC_DST_LSB +: MAC_W];
		to_cpu = dmac == local_mac_addr;
		to_peer = dmac == direct_mac_addr;
		if (!good || !(to_cpu || to_peer))
			return;
		if (cur.size() >= BUF_WORDS) begin // too big even for an empty store
			n_drop++;
			return;
		end
		n_kept++;
		foreach (cur[i]) begin
			w = cur[i];
			if (w.tag == TAG_HEAD)
				w.data[META_OUTPORT_LSB +: PORT_W] = to_cpu ? CPU_PORT : PEER_PORT;
			exp_q.push_back(w);
		end
	endtask

	task automatic check_word();
		pkt_word_t want;
		logic      want_vwr;
		if (exp_q.size() == 0) begin
			$display("%0t: output word while no packet is expected", $time);
			n_proto++;
			return;
		end
		want = exp_q.pop_front();
		want_vwr = want.tag == TAG_TAIL;
		if (pktout !== want) begin
			$display("ERR %0t pktout: got %h expected %h", $time, pktout, want);
			n_data++;
		end
		if (pktout_valid_wr !== want_vwr) begin
			$display("ERR %0t pktout_valid_wr: got %b expected %b", $time,
				pktout_valid_wr, want_vwr);
			n_proto++;
		end
		if (pktout.tag == TAG_HEAD)
			in_burst = 1'b1;
		else if (pktout.tag == TAG_TAIL)
			in_burst = 1'b0;
	endtask

	task automatic check_cnt(input string name, input pkt_cnt_t got, input int want);
		if (got !== pkt_cnt_t'(want)) begin
			$display("ERR %0t %s: got %0d expected %0d", $time, name, got, want);
			n_cnt++;
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (pktin_data_wr) begin
				if (pktin.tag == TAG_HEAD) begin
					cur.delete();
					n_in++;
				end
				cur.push_back(pktin);
				if (pktin.tag == TAG_TAIL)
					close_pkt(pktin_valid_wr && pktin_valid); // verdict comes with the tail
			end
			if (pktout_data_wr) begin
				check_word();
			end else begin
				if (in_burst) begin
					$display("%0t: output burst broken before its tail", $time);
					n_proto++;
					in_burst = 1'b0;
				end
				if (pktout_valid_wr !== 1'b0) begin
					$display("ERR %0t pktout_valid_wr: got %b expected 0", $time,
						pktout_valid_wr);
					n_proto++;
				end
			end
			if (pktout_valid_wr && pktout_valid !== 1'b1) begin
				$display("ERR %0t pktout_valid: got %b expected 1", $time, pktout_valid);
				n_proto++;
			end
			if (chk_counts && !done) begin
				check_cnt("esw_pktin_cnt", esw_pktin_cnt, n_in);
				check_cnt("esw_pktout_cnt", esw_pktout_cnt, n_kept);
				check_cnt("bufm_drop_cnt", bufm_drop_cnt, n_drop);
				done = 1'b1;
			end
		end
		n_left = exp_q.size();
	end

endmodule

/* verification/um_tb.sv */
`timescale 1ns/1ps

module um_tb;
	import um_pkt_pkg::*;

	typedef enum logic [1:0] {
		SEL_LOCAL,
		SEL_DIRECT,
		SEL_OTHER
	} dst_sel_t;

	typedef struct packed {
		dst_sel_t   sel;
		logic [6:0] n_pay; // payload words with the tail last
		logic       valid;
		logic [7:0] gap;   // idle cycles before the packet
	} pkt_spec_t;

	localparam int N_PKT = 11;
	localparam mac_addr_t LOCAL_MAC = 48'h02_11_22_33_44_55;
	localparam mac_addr_t DIRECT_MAC = 48'h02_66_77_88_99_aa;

	localparam pkt_spec_t PKT_TBL [N_PKT] = '{
		'{SEL_LOCAL,  7'd4,  1'b1, 8'd2},
		'{SEL_DIRECT, 7'd10, 1'b1, 8'd0},
		'{SEL_OTHER,  7'd6,  1'b1, 8'd3},
		'{SEL_LOCAL,  7'd8,  1'b0, 8'd1},
		'{SEL_DIRECT, 7'd1,  1'b1, 8'd4},
		'{SEL_LOCAL,  7'd70, 1'b1, 8'd80}, // overflows an empty store
		'{SEL_LOCAL,  7'd20, 1'b1, 8'd5},
		'{SEL_DIRECT, 7'd30, 1'b1, 8'd0},
		'{SEL_OTHER,  7'd3,  1'b0, 8'd2},
		'{SEL_LOCAL,  7'd12, 1'b1, 8'd0},
		'{SEL_DIRECT, 7'd40, 1'b1, 8'd3}
	};

	logic      clk;
	logic      rst_n;
	pkt_word_t pktin;
	logic      pktin_data_wr;
	logic      pktin_valid;
	logic      pktin_valid_wr;
	mac_addr_t local_mac_addr;
	mac_addr_t direct_mac_addr;
	pkt_word_t pktout;
	logic      pktout_data_wr;
	logic      pktout_valid;
	logic      pktout_valid_wr;
	pkt_cnt_t  esw_pktin_cnt;
	pkt_cnt_t  esw_pktout_cnt;
	pkt_cnt_t  bufm_drop_cnt;
	logic      chk_counts;
	logic      counts_done;
	int        exp_left;
	int        data_errs;
	int        proto_errs;
	int        cnt_errs;
	int        n_err;
	int        seed = 6020;
	int        cyc = 0;
	int        limit;

	um_top i_dut (.*);

	um_scoreboard i_sb (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic int run_limit();
		int sum;
		sum = 0;
		for (int i = 0; i < N_PKT; i++)
			sum += PKT_TBL[i].n_pay + 3 + PKT_TBL[i].gap;
		return sum * 2 + 200;
	endfunction

	function automatic pkt_data_t rand_data();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic mac_addr_t dmac_of(input dst_sel_t sel);
		case (sel)
			SEL_LOCAL:  return LOCAL_MAC;
			SEL_DIRECT: return DIRECT_MAC;
			default:    return {16'h0bad, 32'($random(seed))}; // matches neither
		endcase
	endfunction

	// two metadata words and the mac header come before the payload
	task automatic send_pkt(input pkt_spec_t spec);
		pkt_word_t w;
		int        n_words;
		n_words = spec.n_pay + 3;
		repeat (spec.gap) begin
			@(posedge clk);
			pktin_data_wr <= 1'b0;
			pktin_valid_wr <= 1'b0;
		end
		for (int i = 0; i < n_words; i++) begin
			w.tag = (i == 0) ? TAG_HEAD : (i == n_words - 1) ? TAG_TAIL : TAG_MID;
			w.empty = (i == n_words - 1) ? pkt_empty_t'($random(seed)) : '0;
			w.data = rand_data();
			if (i == 2)
				w.data[MAC_DST_LSB +: MAC_W] = dmac_of(spec.sel);
			@(posedge clk);
			pktin <= w;
			pktin_data_wr <= 1'b1;
			pktin_valid_wr <= w.tag == TAG_TAIL;
			pktin_valid <= (w.tag == TAG_TAIL) && spec.valid;
		end
	endtask

	initial begin
		limit = run_limit();
		rst_n = 1'b0;
		pktin = '0;
		pktin_data_wr = 1'b0;
		pktin_valid = 1'b0;
		pktin_valid_wr = 1'b0;
		local_mac_addr = LOCAL_MAC;
		direct_mac_addr = DIRECT_MAC;
		chk_counts = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < N_PKT; i++)
			send_pkt(PKT_TBL[i]);
		@(posedge clk);
		pktin_data_wr <= 1'b0;
		pktin_valid_wr <= 1'b0;
		pktin_valid <= 1'b0;
		@(posedge clk);
		while (exp_left != 0)
			@(posedge clk);
		repeat (20) @(posedge clk); // room for stray output
		chk_counts <= 1'b1;
		while (!counts_done)
			@(posedge clk);
		@(negedge clk);
		n_err = data_errs + proto_errs + cnt_errs + i_dut.u_chk.fail_cnt;
		$display("errors: data %0d, protocol %0d, counters %0d, assertions %0d",
			data_errs, proto_errs, cnt_errs, i_dut.u_chk.fail_cnt);
		if (n_err == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* verification/um_tb_chk.sv */
`timescale 1ns/1ps

module um_tb_chk (
	input logic                  clk,
	input logic                  rst_n,
	input um_pkt_pkg::pkt_word_t pktout,
	input logic                  pktout_data_wr,
	input logic                  pktout_valid_wr
);
	import um_pkt_pkg::*;

	int   fail_cnt = 0;
	logic in_pkt; // head seen and tail pending
	logic head_out;
	logic tail_out;

	assign head_out = pktout_data_wr && pktout.tag == TAG_HEAD;
	assign tail_out = pktout_data_wr && pktout.tag == TAG_TAIL;

	always_ff @(posedge clk) begin
		if (!rst_n)
			in_pkt <= 1'b0;
		else if (head_out)
			in_pkt <= 1'b1;
		else if (tail_out)
			in_pkt <= 1'b0;
	end

	a_valid_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
		pktout_valid_wr |-> pktout_data_wr)
	else begin
		$error("pktout_valid_wr without pktout_data_wr");
		fail_cnt++;
	end

	a_head_no_open: assert property (@(posedge clk) disable iff (!rst_n)
		head_out |-> !in_pkt)
	else begin
		$error("head word before the tail of the previous packet");
		fail_cnt++;
	end

	a_tail_open: assert property (@(posedge clk) disable iff (!rst_n)
		tail_out |-> in_pkt)
	else begin
		$error("tail word without a head");
		fail_cnt++;
	end

	// registered outputs are low one edge after reset is seen
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !pktout_data_wr && !pktout_valid_wr)
	else begin
		$error("output strobe during reset");
		fail_cnt++;
	end

endmodule

bind um_top um_tb_chk u_chk (
	.clk             (clk),
	.rst_n           (rst_n),
	.pktout          (pktout),
	.pktout_data_wr  (pktout_data_wr),
	.pktout_valid_wr (pktout_valid_wr)
);
